//--- Makefile
# verilator build and run of the hdmi tx core testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module hdmi_tx_core_tb -o hdmi_tx_core_tb --Mdir obj_dir
	./obj_dir/hdmi_tx_core_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "result: run ended early"; exit 1; fi
	@echo "result: pass"

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
verilog/video_timing_pkg.sv
verilog/tmds_pkg.sv
verilog/video_sig_gen.sv
verilog/frame_buffer.sv
verilog/tmds_encoder.sv
verilog/hdmi_tx_core.sv
sim/hdmi_tx_core_props.sv
sim/hdmi_tx_core_tb.sv

//--- sim/hdmi_tx_core_props.sv
module hdmi_tx_core_props (
  input logic                                 clk_pixel,
  input logic                                 rst_n,
  input logic                                 video_enable,
  input logic signed [tmds_pkg::disp_w-1:0]   tally,
  input logic                                 new_frame,
  input logic                                 h_sync,
  input logic                                 active_draw,
  input video_timing_pkg::scan_state_e        scan_state
);
  import video_timing_pkg::*;
  import tmds_pkg::*;

  localparam int frame_len = h_total * v_total;  // 288 pixel clocks
  localparam logic signed [disp_w-1:0] tally_max = 8;

  // disparity never drifts past one byte either way
  tally_bounded: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    !$isunknown(tally) |-> (tally >= -tally_max && tally <= tally_max))
    else $error("encoder running disparity out of range");

  tally_cleared: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    !video_enable |=> (tally == '0))  // blanking restarts the balance
    else $error("encoder running disparity not cleared after a control cycle");

  frame_pulse_short: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    new_frame |=> !new_frame)
    else $error("new_frame longer than one cycle");

  frame_pulse_period: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    new_frame |-> ##frame_len new_frame)
    else $error("new_frame did not repeat after one frame");

  no_draw_in_sync: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    !(active_draw && h_sync))
    else $error("active_draw high during h_sync");

  // sync region spans h_sync_len pixels, back porch follows
  sync_region_len: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    $rose(scan_state == H_SYNC) |-> ##h_sync_len (scan_state == H_BACK))
    else $error("horizontal sync region has the wrong length");

endmodule

// encoder side, timing ports idle
bind tmds_encoder hdmi_tx_core_props u_encoder_props (
  .clk_pixel    (clk_pixel),
  .rst_n        (rst_n),
  .video_enable (video_enable),
  .tally        (tally),
  .new_frame    (1'b0),
  .h_sync       (1'b0),
  .active_draw  (1'b0),
  .scan_state   (video_timing_pkg::H_ACTIVE)
);

// timing side, encoder ports idle
bind video_sig_gen hdmi_tx_core_props u_timing_props (
  .clk_pixel    (clk_pixel),
  .rst_n        (rst_n),
  .video_enable (1'b1),
  .tally        ('0),
  .new_frame    (new_frame),
  .h_sync       (h_sync),
  .active_draw  (active_draw),
  .scan_state   (scan_state)
);

//--- sim/hdmi_tx_core_tb.sv
module hdmi_tx_core_tb;
  import video_timing_pkg::*;
  import tmds_pkg::*;

  localparam int frame_len  = h_total * v_total;  // symbols per frame
  localparam int wait_limit = 3 * frame_len;      // three frames for any wait

  logic                 clk_pixel = 1'b0;
  logic                 rst_n;
  logic                 wr_en;
  logic [fb_addr_w-1:0] wr_addr;
  logic [pixel_w-1:0]   wr_data;
  logic [tmds_w-1:0]    tmds_red;
  logic [tmds_w-1:0]    tmds_green;
  logic [tmds_w-1:0]    tmds_blue;
  logic                 new_frame_out;

  logic [pixel_w-1:0] model_mem [fb_depth];  // expected frame buffer contents
  int    seed = 77;
  string test_name;
  int    test_errors;
  int    test_checks;
  int    tests_run;
  int    tests_failed;
  logic  timed_out;
  logic  check_go;    // rising edge starts the comparing process
  logic  check_done;

  always #2 clk_pixel = ~clk_pixel;

  hdmi_tx_core u_hdmi_tx_core (
    .clk_pixel     (clk_pixel),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .tmds_red      (tmds_red),
    .tmds_green    (tmds_green),
    .tmds_blue     (tmds_blue),
    .new_frame_out (new_frame_out)
  );

  // receiver side decode, result is {is_control, c1, c0, byte}
  function automatic logic [10:0] decode_symbol(input logic [tmds_w-1:0] sym);
    logic [color_w-1:0] d;
    logic [color_w-1:0] b;
    if (sym == ctrl_token_00) return {1'b1, 2'b00, 8'h00};
    if (sym == ctrl_token_01) return {1'b1, 2'b01, 8'h00};
    if (sym == ctrl_token_10) return {1'b1, 2'b10, 8'h00};
    if (sym == ctrl_token_11) return {1'b1, 2'b11, 8'h00};
    d = sym[9] ? ~sym[7:0] : sym[7:0];  // bit 9 marks an inverted word
    b[0] = d[0];
    for (int i = 1; i < color_w; i++) begin
      b[i] = sym[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);  // bit 8 high means xor chain
    end
    return {3'b000, b};
  endfunction

  // rgb332 widened per channel, ch 0 red, 1 green, 2 blue
  function automatic logic [color_w-1:0] expand_channel(input logic [pixel_w-1:0] p, input int ch);
    case (ch)
      0:       return {p[7:5], 5'b00000};
      1:       return {p[4:2], 5'b00000};
      default: return {p[1:0], 6'b000000};
    endcase
  endfunction

  // decoded value expected at raster position (h, v)
  function automatic logic [10:0] expect_symbol(input int h, input int v, input int ch);
    logic hs;
    logic vs;
    hs = (h >= h_active + h_front) && (h < h_active + h_front + h_sync_len);
    vs = (v >= v_active + v_front) && (v < v_active + v_front + v_sync_len);
    if (h < h_active && v < v_active) begin
      return {3'b000, expand_channel(model_mem[fb_addr_w'(v * h_active + h)], ch)};
    end
    return (ch == 2) ? {1'b1, vs, hs, 8'h00} : {1'b1, 2'b00, 8'h00};  // syncs ride on blue
  endfunction

  task automatic check_value(input string what, input logic [10:0] expected,
                             input logic [10:0] actual);
    test_checks++;
    assert (actual === expected) else begin
      $display("MISMATCH %s %s expected 'h%0h actual 'h%0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  // returns on the negedge where new_frame_out is high
  task automatic wait_new_frame();
    int n;
    n = 0;
    @(negedge clk_pixel);
    while (!new_frame_out && n < wait_limit) begin
      @(negedge clk_pixel);
      n++;
    end
    if (!new_frame_out) begin
      $display("error in %s: no new_frame_out pulse within three frames", test_name);
      test_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic write_pixel(input logic [fb_addr_w-1:0] addr, input logic [pixel_w-1:0] data);
    @(posedge clk_pixel);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    model_mem[addr] = data;
  endtask

  task automatic end_writes();
    @(posedge clk_pixel);
    wr_en <= 1'b0;
  endtask

  // hand one frame to the comparing process and wait until it is through
  task automatic run_frame_check();
    int n;
    n = 0;
    check_done = 1'b0;
    check_go   = 1'b1;
    while (!check_done && n < 5 * frame_len) begin
      @(negedge clk_pixel);
      n++;
    end
    check_go = 1'b0;
    if (!check_done) begin
      $display("error in %s: frame comparison did not finish in time", test_name);
      test_errors++;
      timed_out = 1'b1;
    end
  endtask

  // walks the raster in step with the symbols, starting at pixel (0,0)
  always @(posedge check_go) begin
    int    h;
    int    v;
    string ch_name;
    logic [tmds_w-1:0] sym;
    wait_new_frame();
    for (int k = 0; k < frame_len && !timed_out; k++) begin
      if (k != 0) begin
        @(negedge clk_pixel);
      end
      h = k % h_total;
      v = k / h_total;
      for (int ch = 0; ch < 3; ch++) begin
        sym     = (ch == 0) ? tmds_red : ((ch == 1) ? tmds_green : tmds_blue);
        ch_name = (ch == 0) ? "red" : ((ch == 1) ? "green" : "blue");
        check_value($sformatf("%s at (%0d,%0d)", ch_name, h, v), expect_symbol(h, v, ch),
                    decode_symbol(sym));
      end
    end
    check_done = 1'b1;
  end

  task automatic run_tests();
    int r;
    int n;
    start_test("reset_tokens");  // pipeline still idle for a few cycles after reset
    repeat (4) begin
      @(negedge clk_pixel);
      check_value("red", {1'b0, ctrl_token_00}, {1'b0, tmds_red});
      check_value("green", {1'b0, ctrl_token_00}, {1'b0, tmds_green});
      check_value("blue", {1'b0, ctrl_token_00}, {1'b0, tmds_blue});
    end
    finish_test();

    start_test("random_frame");  // active pixels and blanking tokens
    for (int i = 0; i < fb_depth; i++) begin
      r = $random(seed);
      write_pixel(fb_addr_w'(i), r[pixel_w-1:0]);
    end
    end_writes();
    run_frame_check();
    finish_test();
    if (timed_out) return;

    start_test("corner_colors");
    for (int i = 0; i < fb_depth; i++) begin
      case ((i ^ (i >> 3) ^ (i >> 6)) % 8)  // spread over the whole address
        0:       write_pixel(fb_addr_w'(i), 8'h00);
        1:       write_pixel(fb_addr_w'(i), 8'hff);
        2:       write_pixel(fb_addr_w'(i), 8'h0f);
        3:       write_pixel(fb_addr_w'(i), 8'hf0);
        4:       write_pixel(fb_addr_w'(i), 8'h92);
        5:       write_pixel(fb_addr_w'(i), 8'h6d);
        6:       write_pixel(fb_addr_w'(i), 8'he3);
        default: write_pixel(fb_addr_w'(i), 8'h1c);
      endcase
    end
    end_writes();
    run_frame_check();
    finish_test();
    if (timed_out) return;

    start_test("rewrite");
    wait_new_frame();
    if (!timed_out) begin
      for (int i = 0; i < 16; i++) begin  // lands mid frame, shows up in the next one
        r = $random(seed);
        write_pixel(r[fb_addr_w-1:0], r[15:8]);
      end
      end_writes();
      run_frame_check();
    end
    finish_test();
    if (timed_out) return;

    start_test("frame_period");
    wait_new_frame();
    if (!timed_out) begin
      n = 0;
      do begin
        @(negedge clk_pixel);
        n++;
      end while (!new_frame_out && n < wait_limit);
      if (!new_frame_out) begin
        $display("error in %s: no second new_frame_out pulse within three frames", test_name);
        test_errors++;
        timed_out = 1'b1;
      end else begin
        check_value("symbols per frame", 11'(frame_len), 11'(n));
      end
    end
    finish_test();
  endtask

  initial begin
    rst_n        = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    check_go     = 1'b0;
    check_done   = 1'b0;
    timed_out    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk_pixel);
    rst_n <= 1'b1;
    run_tests();
    $display("summary: %0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/frame_buffer.sv
module frame_buffer (
  input  logic                                   clk_pixel,
  input  logic                                   rst_n,
  input  logic                                   wr_en,
  input  logic [video_timing_pkg::fb_addr_w-1:0] wr_addr,
  input  logic [video_timing_pkg::pixel_w-1:0]   wr_data,
  input  logic [video_timing_pkg::h_count_w-1:0] h_count,
  input  logic [video_timing_pkg::v_count_w-1:0] v_count,
  input  logic                                   h_sync,
  input  logic                                   v_sync,
  input  logic                                   active_draw,
  input  logic                                   new_frame,
  output logic [tmds_pkg::color_w-1:0]           red,
  output logic [tmds_pkg::color_w-1:0]           green,
  output logic [tmds_pkg::color_w-1:0]           blue,
  output logic                                   h_sync_q,
  output logic                                   v_sync_q,
  output logic                                   active_q,
  output logic                                   new_frame_q
);
  import video_timing_pkg::*;
  import tmds_pkg::*;

  logic [pixel_w-1:0]   mem [fb_depth];  // rgb332 pixels, row major
  logic [fb_addr_w-1:0] rd_addr;         // stage one
  logic [pixel_w-1:0]   pixel_q;         // stage two

  // {new_frame, active_draw, v_sync, h_sync} per stage
  logic [read_latency-1:0][3:0] timing_pipe;

  // single write port plus registered read
  // read of a location written this cycle sees the old pixel
  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // row * h_active + col, blanking positions give don't care addresses
    rd_addr <= fb_addr_w'(v_count * h_active + h_count);
    pixel_q <= mem[rd_addr];
  end

  // rgb332 to 8 bits per channel, low bits zero filled
  assign red   = {pixel_q[7:5], {(color_w - 3){1'b0}}};
  assign green = {pixel_q[4:2], {(color_w - 3){1'b0}}};
  assign blue  = {pixel_q[1:0], {(color_w - 2){1'b0}}};

  // delay the timing signals by the read latency so they stay with the color
  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      timing_pipe <= '0;
    end else begin
      timing_pipe <= {timing_pipe[read_latency-2:0], {new_frame, active_draw, v_sync, h_sync}};
    end
  end

  assign {new_frame_q, active_q, v_sync_q, h_sync_q} = timing_pipe[read_latency-1];

endmodule

//--- verilog/hdmi_tx_core.sv
module hdmi_tx_core (
  input  logic                                   clk_pixel,
  input  logic                                   rst_n,
  input  logic                                   wr_en,    // pixel write strobe
  input  logic [video_timing_pkg::fb_addr_w-1:0] wr_addr,
  input  logic [video_timing_pkg::pixel_w-1:0]   wr_data,
  output logic [tmds_pkg::tmds_w-1:0]            tmds_red,
  output logic [tmds_pkg::tmds_w-1:0]            tmds_green,
  output logic [tmds_pkg::tmds_w-1:0]            tmds_blue,
  output logic                                   new_frame_out  // marks symbol of pixel (0,0)
);
  import video_timing_pkg::*;
  import tmds_pkg::*;

  // raw timing from the generator
  logic [h_count_w-1:0] h_count;
  logic [v_count_w-1:0] v_count;
  logic                 h_sync;
  logic                 v_sync;
  logic                 active_draw;
  logic                 new_frame;

  // colors and timing after the buffer read latency
  logic [color_w-1:0] red;
  logic [color_w-1:0] green;
  logic [color_w-1:0] blue;
  logic               h_sync_q;
  logic               v_sync_q;
  logic               active_q;
  logic               new_frame_q;

  video_sig_gen u_video_sig_gen (
    .clk_pixel   (clk_pixel),
    .rst_n       (rst_n),
    .h_count     (h_count),
    .v_count     (v_count),
    .h_sync      (h_sync),
    .v_sync      (v_sync),
    .active_draw (active_draw),
    .new_frame   (new_frame),
    .frame_count ()             // not needed in the display path
  );

  frame_buffer u_frame_buffer (
    .clk_pixel   (clk_pixel),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .h_count     (h_count),
    .v_count     (v_count),
    .h_sync      (h_sync),
    .v_sync      (v_sync),
    .active_draw (active_draw),
    .new_frame   (new_frame),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .h_sync_q    (h_sync_q),
    .v_sync_q    (v_sync_q),
    .active_q    (active_q),
    .new_frame_q (new_frame_q)
  );

  // blue carries the syncs in its control tokens
  tmds_encoder u_tmds_blue (
    .clk_pixel    (clk_pixel),
    .rst_n        (rst_n),
    .video_data   (blue),
    .control      ({v_sync_q, h_sync_q}),
    .video_enable (active_q),
    .tmds         (tmds_blue)
  );

  tmds_encoder u_tmds_green (
    .clk_pixel    (clk_pixel),
    .rst_n        (rst_n),
    .video_data   (green),
    .control      (2'b00),
    .video_enable (active_q),
    .tmds         (tmds_green)
  );

  tmds_encoder u_tmds_red (
    .clk_pixel    (clk_pixel),
    .rst_n        (rst_n),
    .video_data   (red),
    .control      (2'b00),
    .video_enable (active_q),
    .tmds         (tmds_red)
  );

  // one more stage to match the encoder register
  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      new_frame_out <= 1'b0;
    end else begin
      new_frame_out <= new_frame_q;
    end
  end

endmodule

//--- verilog/tmds_encoder.sv
module tmds_encoder (
  input  logic                         clk_pixel,
  input  logic                         rst_n,
  input  logic [tmds_pkg::color_w-1:0] video_data,
  input  logic [1:0]                   control,       // {c1, c0}
  input  logic                         video_enable,  // low selects control tokens
  output logic [tmds_pkg::tmds_w-1:0]  tmds
);
  import tmds_pkg::*;

  // population count of one channel byte
  function automatic logic [3:0] count_ones(input logic [color_w-1:0] bits);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < color_w; i++) begin
      n = n + 4'(bits[i]);
    end
    return n;
  endfunction

  tmds_sel_e                 sel;
  tmds_mode_e                mode;
  logic [3:0]                data_ones;   // ones in the input byte
  logic [3:0]                qm_ones;     // ones in q_m[7:0]
  logic [color_w:0]          q_m;         // transition minimized word
  logic signed [disp_w-1:0]  qm_diff;     // ones minus zeros of q_m[7:0]
  logic signed [disp_w-1:0]  tally;       // running disparity
  logic signed [disp_w-1:0]  tally_next;
  logic [tmds_w-1:0]         tmds_next;

  // stage 1, pick xor or xnor chain
  assign data_ones = count_ones(video_data);
  assign sel = (data_ones > 4'd4 || (data_ones == 4'd4 && !video_data[0])) ? SEL_XNOR : SEL_XOR;
  assign mode = video_enable ? MODE_VIDEO : MODE_CONTROL;

  always_comb begin
    q_m[0] = video_data[0];
    for (int i = 1; i < color_w; i++) begin
      if (sel == SEL_XOR) begin
        q_m[i] = q_m[i-1] ^ video_data[i];
      end else begin
        q_m[i] = ~(q_m[i-1] ^ video_data[i]);
      end
    end
    q_m[color_w] = (sel == SEL_XOR);  // tells the receiver which chain was used
  end

  // 2*ones - 8 equals ones minus zeros
  assign qm_ones = count_ones(q_m[color_w-1:0]);
  assign qm_diff = disp_w'({qm_ones, 1'b0}) - disp_w'(color_w);

  // stage 2 and 3, dc balance or control token
  always_comb begin
    if (mode == MODE_CONTROL) begin
      tally_next = '0;  // balance restarts after blanking
      case (control)
        2'b00:   tmds_next = ctrl_token_00;
        2'b01:   tmds_next = ctrl_token_01;
        2'b10:   tmds_next = ctrl_token_10;
        default: tmds_next = ctrl_token_11;
      endcase
    end else if (tally == 0 || qm_diff == 0) begin
      // no bias either way, invert according to q_m[8]
      tmds_next = {~q_m[color_w], q_m[color_w],
                   q_m[color_w] ? q_m[color_w-1:0] : ~q_m[color_w-1:0]};
      tally_next = q_m[color_w] ? tally + qm_diff : tally - qm_diff;
    end else if ((tally > 0 && qm_diff > 0) || (tally < 0 && qm_diff < 0)) begin
      // word would push further the same way, send it inverted
      tmds_next  = {1'b1, q_m[color_w], ~q_m[color_w-1:0]};
      tally_next = tally - qm_diff + (q_m[color_w] ? disp_w'(2) : disp_w'(0));
    end else begin
      tmds_next  = {1'b0, q_m[color_w], q_m[color_w-1:0]};  // already pulls back
      tally_next = tally + qm_diff - (q_m[color_w] ? disp_w'(0) : disp_w'(2));
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      tmds  <= ctrl_token_00;
      tally <= '0;
    end else begin
      tmds  <= tmds_next;
      tally <= tally_next;
    end
  end

endmodule

//--- verilog/tmds_pkg.sv
package tmds_pkg;

  localparam int tmds_w  = 10;  // one symbol per pixel clock
  localparam int color_w = 8;   // per channel

  // control tokens, indexed by {c1, c0}
  localparam logic [tmds_w-1:0] ctrl_token_00 = 10'b1101010100;
  localparam logic [tmds_w-1:0] ctrl_token_01 = 10'b0010101011;
  localparam logic [tmds_w-1:0] ctrl_token_10 = 10'b0101010100;
  localparam logic [tmds_w-1:0] ctrl_token_11 = 10'b1010101011;

  // signed running disparity, needs to hold +-8 comfortably
  localparam int disp_w = 5;

  // transition minimizing choice, stored in q_m[8]
  typedef enum logic {
    SEL_XOR,
    SEL_XNOR
  } tmds_sel_e;

  // what the channel carries this cycle
  typedef enum logic {
    MODE_CONTROL,
    MODE_VIDEO
  } tmds_mode_e;

endpackage

//--- verilog/video_sig_gen.sv
module video_sig_gen (
  input  logic                                 clk_pixel,
  input  logic                                 rst_n,
  output logic [video_timing_pkg::h_count_w-1:0] h_count,
  output logic [video_timing_pkg::v_count_w-1:0] v_count,
  output logic                                 h_sync,
  output logic                                 v_sync,
  output logic                                 active_draw,
  output logic                                 new_frame,
  output logic [5:0]                           frame_count
);
  import video_timing_pkg::*;

  scan_state_e          scan_state;       // region of the current h_count
  scan_state_e          scan_state_next;
  logic [h_count_w-1:0] h_next;
  logic [v_count_w-1:0] v_next;
  logic                 line_end;         // last pixel of a line
  logic                 frame_end;        // last pixel of the frame

  assign line_end  = (h_count == h_count_w'(h_total - 1));
  assign frame_end = line_end && (v_count == v_count_w'(v_total - 1));

  // next counter values, all outputs below are registered from these
  assign h_next = line_end ? '0 : h_count + 1'b1;
  assign v_next = frame_end ? '0 : (line_end ? v_count + 1'b1 : v_count);

  // region fsm steps on the last pixel of each region
  always_comb begin
    scan_state_next = scan_state;
    case (scan_state)
      H_ACTIVE: begin
        if (h_count == h_count_w'(h_active - 1)) begin
          scan_state_next = H_FRONT;
        end
      end
      H_FRONT: begin
        if (h_count == h_count_w'(h_active + h_front - 1)) begin
          scan_state_next = H_SYNC;
        end
      end
      H_SYNC: begin
        if (h_count == h_count_w'(h_active + h_front + h_sync_len - 1)) begin
          scan_state_next = H_BACK;
        end
      end
      H_BACK: begin
        if (line_end) begin
          scan_state_next = H_ACTIVE;  // wrap to start of next line
        end
      end
      default: scan_state_next = H_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      h_count     <= '0;
      v_count     <= '0;
      scan_state  <= H_ACTIVE;  // h_count 0 sits in active region
      h_sync      <= 1'b0;
      v_sync      <= 1'b0;
      active_draw <= 1'b0;
      new_frame   <= 1'b0;
      frame_count <= '0;
    end else begin
      h_count    <= h_next;
      v_count    <= v_next;
      scan_state <= scan_state_next;
      // levels line up with the counter values they describe
      h_sync <= (scan_state_next == H_SYNC);
      v_sync <= (v_next >= v_count_w'(v_active + v_front)) &&
                (v_next < v_count_w'(v_active + v_front + v_sync_len));
      active_draw <= (scan_state_next == H_ACTIVE) && (v_next < v_count_w'(v_active));
      new_frame   <= frame_end;  // next position is (0,0)
      if (frame_end) begin
        frame_count <= (frame_count == 6'(frame_count_max)) ? '0 : frame_count + 1'b1;
      end
    end
  end

endmodule

//--- verilog/video_timing_pkg.sv
package video_timing_pkg;

  // horizontal raster, in pixel clocks
  localparam int h_active   = 16;  // visible pixels per line
  localparam int h_front    = 2;   // front porch right after active video
  localparam int h_sync_len = 3;
  localparam int h_back     = 3;
  localparam int h_total    = h_active + h_front + h_sync_len + h_back;  // 24

  // vertical raster, in lines
  localparam int v_active   = 8;
  localparam int v_front    = 1;
  localparam int v_sync_len = 2;
  localparam int v_back     = 1;
  localparam int v_total    = v_active + v_front + v_sync_len + v_back;  // 12

  // counter widths sized to cover the whole raster
  localparam int h_count_w = $clog2(h_total);  // 5
  localparam int v_count_w = $clog2(v_total);  // 4

  // frame buffer holds active pixels only, row major
  localparam int fb_depth  = h_active * v_active;  // 128
  localparam int fb_addr_w = $clog2(fb_depth);     // 7
  localparam int pixel_w   = 8;                    // rgb332

  localparam int frame_count_max = 59;  // frame counter wraps here

  // counters to expanded color: address reg + ram read
  localparam int read_latency = 2;

  // horizontal region of the scan
  typedef enum logic [1:0] {
    H_ACTIVE,
    H_FRONT,
    H_SYNC,
    H_BACK
  } scan_state_e;

endpackage
